// ==== tetris_defines.svh ====
// board geometry is fixed by the 72-bit tetris output and must not be changed alone
`ifndef TETRIS_DEFINES_SVH
`define TETRIS_DEFINES_SVH

// --------------------------------------------------
// board geometry
// --------------------------------------------------

// columns across the board
`define BOARD_COLS 6

// stored rows, two hidden rows on top hold overflow
`define BOARD_ROWS 14

// rows shown on the tetris output
`define VISIBLE_ROWS 12

// --------------------------------------------------
// game limits
// --------------------------------------------------
`define PIECES_PER_GAME 16
`define HEIGHT_W 4

`endif

// ==== tetris_pkg.sv ====
// row 0 is the bottom of the board and bit c of a row is column c
`include "tetris_defines.svh"

package tetris_pkg;

	// --------------------------------------------------
	// board storage
	// --------------------------------------------------

	// one board row
	typedef logic [`BOARD_COLS-1:0] row_t;

	// whole stored board including the hidden rows
	typedef row_t [`BOARD_ROWS-1:0] board_t;

	// index of the lowest empty cell above the stack
	typedef logic [`HEIGHT_W-1:0] height_t;

	// --------------------------------------------------
	// round inputs and outputs
	// --------------------------------------------------

	// shape code 0 to 7
	typedef logic [2:0] piece_t;

	// left column of the piece bounding box
	typedef logic [2:0] col_t;

	typedef logic [3:0] score_t;

	// round sequencing
	typedef enum logic [1:0] {
		IDLE,
		PLACE,
		DETECT
	} game_state_t;

endpackage

// ==== board_if.sv ====
// the store accepts at most one command per edge and the controller keeps them exclusive
`timescale 1ns/1ps

interface board_if;
	import tetris_pkg::*;

	// current board and full row flag from the store
	board_t board;
	logic row_full;

	// commands
	logic place_en;
	board_t place_mask;
	logic clear_en;
	logic wipe;

	modport store (
		output board,
		output row_full,
		input place_en,
		input place_mask,
		input clear_en,
		input wipe
	);

	modport lander (
		output place_mask
	);

	modport ctrl (
		input board,
		input row_full,
		output place_en,
		output clear_en,
		output wipe
	);
endinterface

// ==== board_store.sv ====
// applies one command per edge with wipe over clear over place and clears one row per edge
`timescale 1ns/1ps
`include "tetris_defines.svh"

module board_store (
	input logic clk,
	input logic rst_n,
	board_if.store bus
);
	import tetris_pkg::*;

	board_t board_q;
	board_t board_down;
	board_t board_cleared;
	logic [`HEIGHT_W-1:0] full_idx;
	logic full_found;

	// --------------------------------------------------
	// lowest full row search
	// --------------------------------------------------

	// scan from the top so the last hit is the lowest row
	always_comb begin
		full_idx = '0;
		full_found = 1'b0;
		for (int r = `BOARD_ROWS - 1; r >= 0; r--) begin
			if (&board_q[r]) begin
				full_idx = `HEIGHT_W'(r);
				full_found = 1'b1;
			end
		end
	end

	// --------------------------------------------------
	// row clear
	// --------------------------------------------------

	// every row moved down by one, top row comes in empty
	assign board_down = board_q >> `BOARD_COLS;

	// rows below the cleared one keep their place
	always_comb begin
		for (int r = 0; r < `BOARD_ROWS; r++) begin
			if (r < full_idx) begin
				board_cleared[r] = board_q[r];
			end else begin
				board_cleared[r] = board_down[r];
			end
		end
	end

	// --------------------------------------------------
	// board register
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			board_q <= '0;
		end else if (bus.wipe) begin
			board_q <= '0;
		end else if (bus.clear_en) begin
			board_q <= board_cleared;
		end else if (bus.place_en) begin
			// the lander never overlaps filled cells
			board_q <= board_q | bus.place_mask;
		end
	end

	assign bus.board = board_q;
	assign bus.row_full = full_found;

endmodule

// ==== column_height.sv ====
// a column height counts up to its top filled cell and ignores any holes below it
`timescale 1ns/1ps
`include "tetris_defines.svh"

module column_height (
	input tetris_pkg::board_t board,
	output tetris_pkg::height_t [`BOARD_COLS-1:0] heights,
	output logic overflow
);
	import tetris_pkg::*;

	// --------------------------------------------------
	// per column priority encoders
	// --------------------------------------------------

	// upward scan so the highest filled cell wins
	always_comb begin
		for (int c = 0; c < `BOARD_COLS; c++) begin
			heights[c] = '0;
			for (int r = 0; r < `BOARD_ROWS; r++) begin
				if (board[r][c]) begin
					heights[c] = height_t'(r + 1);
				end
			end
		end
	end

	// --------------------------------------------------
	// overflow into the hidden rows
	// --------------------------------------------------
	always_comb begin
		overflow = 1'b0;
		for (int c = 0; c < `BOARD_COLS; c++) begin
			if (heights[c] > `VISIBLE_ROWS) begin
				overflow = 1'b1;
			end
		end
	end

endmodule

// ==== piece_lander.sv ====
// assumes the piece fits inside the board width and cells above the stored rows are dropped
`timescale 1ns/1ps
`include "tetris_defines.svh"

module piece_lander (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input tetris_pkg::piece_t tetrominoes,
	input tetris_pkg::col_t position,
	input tetris_pkg::height_t [`BOARD_COLS-1:0] heights,
	board_if.lander bus
);
	import tetris_pkg::*;

	piece_t piece_q;
	col_t pos_q;
	height_t [3:0] cand_d;
	height_t [3:0] cand_q;
	height_t [`BOARD_COLS-1:0] h_win;
	height_t landing;
	height_t bottom;
	logic [3:0][3:0] pattern;
	row_t [3:0] piece_rows;
	board_t mask;

	// shape rows from the bottom edge, bit 0 is the left column
	function automatic logic [3:0][3:0] shape_rows(input piece_t p);
		case (p)
			3'd0: shape_rows = {4'b0000, 4'b0000, 4'b0011, 4'b0011};
			3'd1: shape_rows = {4'b0001, 4'b0001, 4'b0001, 4'b0001};
			3'd2: shape_rows = {4'b0000, 4'b0000, 4'b0000, 4'b1111};
			3'd3: shape_rows = {4'b0000, 4'b0011, 4'b0010, 4'b0010};
			3'd4: shape_rows = {4'b0000, 4'b0000, 4'b0111, 4'b0001};
			3'd5: shape_rows = {4'b0000, 4'b0001, 4'b0001, 4'b0011};
			3'd6: shape_rows = {4'b0000, 4'b0001, 4'b0011, 4'b0010};
			default: shape_rows = {4'b0000, 4'b0000, 4'b0110, 4'b0011};
		endcase
	endfunction

	// shape row that the landing candidates refer to
	function automatic height_t anchor_row(input piece_t p);
		case (p)
			3'd3: anchor_row = 4'd2;
			3'd4, 3'd6, 3'd7: anchor_row = 4'd1;
			default: anchor_row = 4'd0;
		endcase
	endfunction

	function automatic height_t max2(input height_t a, input height_t b);
		max2 = (a > b) ? a : b;
	endfunction

	// --------------------------------------------------
	// landing candidates, one per covered column
	// --------------------------------------------------
	assign h_win = heights >> (position * `HEIGHT_W);

	always_comb begin
		cand_d = '0;
		cand_d[0] = h_win[0];
		case (tetrominoes)
			3'd0, 3'd5: cand_d[1] = h_win[1];
			3'd2: cand_d = h_win[3:0];
			3'd3: cand_d[1] = h_win[1] + 4'd2;
			3'd4: begin
				cand_d[0] = h_win[0] + 4'd1;
				cand_d[1] = h_win[1];
				cand_d[2] = h_win[2];
			end
			3'd6: cand_d[1] = h_win[1] + 4'd1;
			3'd7: begin
				cand_d[0] = h_win[0] + 4'd1;
				cand_d[1] = h_win[1] + 4'd1;
				cand_d[2] = h_win[2];
			end
			default: cand_d[0] = h_win[0];
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			piece_q <= '0;
			pos_q <= '0;
			cand_q <= '0;
		end else if (in_valid) begin
			piece_q <= tetrominoes;
			pos_q <= position;
			cand_q <= cand_d;
		end
	end

	// --------------------------------------------------
	// cell mask at the landing row
	// --------------------------------------------------
	always_comb begin
		landing = max2(max2(cand_q[0], cand_q[1]), max2(cand_q[2], cand_q[3]));
		bottom = landing - anchor_row(piece_q);
		pattern = shape_rows(piece_q);
		for (int k = 0; k < 4; k++) begin
			piece_rows[k] = row_t'(pattern[k]) << pos_q;
		end
		mask = '0;
		mask[3:0] = piece_rows;
		bus.place_mask = mask << (bottom * `BOARD_COLS);
	end

endmodule

// ==== game_ctrl.sv ====
// expects the next in_valid only after score_valid and applies no back-pressure
`timescale 1ns/1ps
`include "tetris_defines.svh"

module game_ctrl (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic overflow,
	board_if.ctrl bus,
	output logic score_valid,
	output logic fail,
	output logic tetris_valid,
	output tetris_pkg::score_t score,
	output logic [`VISIBLE_ROWS*`BOARD_COLS-1:0] tetris
);
	import tetris_pkg::*;

	game_state_t state_q;
	game_state_t state_d;
	score_t score_q;
	score_t score_d;
	logic [3:0] piece_cnt_q;
	logic [3:0] piece_cnt_d;
	logic game_over;

	// --------------------------------------------------
	// state, score and piece counter
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= IDLE;
			score_q <= '0;
			piece_cnt_q <= '0;
		end else begin
			state_q <= state_d;
			score_q <= score_d;
			piece_cnt_q <= piece_cnt_d;
		end
	end

	// overflow or the last piece of the game
	assign game_over = overflow || (piece_cnt_q == 4'(`PIECES_PER_GAME - 1));

	// --------------------------------------------------
	// round sequencing and output drive
	// --------------------------------------------------
	always_comb begin
		state_d = state_q;
		score_d = score_q;
		piece_cnt_d = piece_cnt_q;
		bus.place_en = 1'b0;
		bus.clear_en = 1'b0;
		bus.wipe = 1'b0;
		score_valid = 1'b0;
		fail = 1'b0;
		tetris_valid = 1'b0;
		score = '0;
		tetris = '0;
		case (state_q)
			IDLE: begin
				if (in_valid) begin
					state_d = PLACE;
				end
			end
			PLACE: begin
				bus.place_en = 1'b1;
				state_d = DETECT;
			end
			DETECT: begin
				if (bus.row_full) begin
					// one row per cycle
					bus.clear_en = 1'b1;
					score_d = score_q + 1'b1;
				end else begin
					score_valid = 1'b1;
					score = score_q;
					fail = overflow;
					state_d = IDLE;
					if (game_over) begin
						tetris_valid = 1'b1;
						tetris = bus.board[`VISIBLE_ROWS-1:0];
						bus.wipe = 1'b1;
						score_d = '0;
						piece_cnt_d = '0;
					end else begin
						piece_cnt_d = piece_cnt_q + 1'b1;
					end
				end
			end
			default: state_d = IDLE;
		endcase
	end

endmodule

// ==== tetris_top.sv ====
// board is 6 columns by 12 visible rows plus two hidden rows and cannot be resized
`timescale 1ns/1ps
`include "tetris_defines.svh"

module tetris_top (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input tetris_pkg::piece_t tetrominoes,
	input tetris_pkg::col_t position,
	output logic tetris_valid,
	output logic score_valid,
	output logic fail,
	output tetris_pkg::score_t score,
	output logic [`VISIBLE_ROWS*`BOARD_COLS-1:0] tetris
);
	import tetris_pkg::*;

	// stack heights and overflow flag
	height_t [`BOARD_COLS-1:0] heights;
	logic overflow;

	board_if bus ();

	// --------------------------------------------------
	// datapath
	// --------------------------------------------------
	board_store u_board_store (
		.clk(clk),
		.rst_n(rst_n),
		.bus(bus)
	);

	column_height u_column_height (
		.board(bus.board),
		.heights(heights),
		.overflow(overflow)
	);

	piece_lander u_piece_lander (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.tetrominoes(tetrominoes),
		.position(position),
		.heights(heights),
		.bus(bus)
	);

	// --------------------------------------------------
	// control
	// --------------------------------------------------
	game_ctrl u_game_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.overflow(overflow),
		.bus(bus),
		.score_valid(score_valid),
		.fail(fail),
		.tetris_valid(tetris_valid),
		.score(score),
		.tetris(tetris)
	);

endmodule

// ==== tb_tetris_assertions.sv ====
// output handshake rules of tetris_top, checks are off while rst_n is low
`timescale 1ns/1ps

module tb_tetris_assertions (
	input logic clk,
	input logic rst_n,
	input logic score_valid,
	input logic tetris_valid,
	input logic fail
);

	// number of failed properties
	int violations = 0;

	// --------------------------------------------------
	// report handshake
	// --------------------------------------------------

	// one report per round
	score_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
		score_valid |=> !score_valid)
		else begin
			violations++;
			$error("score_valid stayed high for two cycles");
		end

	board_with_score: assert property (@(posedge clk) disable iff (!rst_n)
		tetris_valid |-> score_valid)
		else begin
			violations++;
			$error("tetris_valid without score_valid");
		end

	// a lost game always shows its board
	fail_with_board: assert property (@(posedge clk) disable iff (!rst_n)
		fail |-> tetris_valid)
		else begin
			violations++;
			$error("fail without tetris_valid");
		end

endmodule

bind tetris_top tb_tetris_assertions u_assertions (
	.clk(clk),
	.rst_n(rst_n),
	.score_valid(score_valid),
	.tetris_valid(tetris_valid),
	.fail(fail)
);

// ==== tb_tetris.sv ====
// single-bench run of directed and random rounds; a round that gets no score_valid is an error
`timescale 1ns/1ps
`include "tetris_defines.svh"

module tb_tetris;
	import tetris_pkg::*;

	logic clk;
	logic rst_n;
	logic in_valid;
	piece_t tetrominoes;
	col_t position;
	logic tetris_valid;
	logic score_valid;
	logic fail;
	score_t score;
	logic [`VISIBLE_ROWS*`BOARD_COLS-1:0] tetris;

	// board model, row 0 at the bottom
	logic [`BOARD_COLS-1:0] model_board [`BOARD_ROWS];
	int model_score;
	int model_count;
	logic last_end;
	logic last_fail;
	// what the DUT reported in the last round
	logic dut_end;
	logic dut_fail;
	int mismatches;
	int other_errors;
	int cycles;
	logic [31:0] rng;

	tetris_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// about 90 rounds of at most 12 cycles each, with a wide margin
	always @(posedge clk) begin
		cycles++;
		if (cycles >= 6000) begin
			$display("run stopped after %0d cycles without reaching the end", cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------

	// four cells as {row, col} nibbles from the bottom left of the box
	function automatic logic [15:0] shape_cells(input int p);
		case (p)
			0: return 16'h5410;
			1: return 16'hc840;
			2: return 16'h3210;
			3: return 16'h8951;
			4: return 16'h0654;
			5: return 16'h8410;
			6: return 16'h5184;
			default: return 16'h6510;
		endcase
	endfunction

	function automatic int shape_width(input int p);
		logic [15:0] cells;
		int w;
		cells = shape_cells(p);
		w = 0;
		for (int k = 0; k < 4; k++) begin
			if (cells[4*k +: 2] + 1 > w) begin
				w = cells[4*k +: 2] + 1;
			end
		end
		return w;
	endfunction

	function automatic int col_height(input int c);
		int h;
		h = 0;
		for (int r = 0; r < `BOARD_ROWS; r++) begin
			if (model_board[r][c]) begin
				h = r + 1;
			end
		end
		return h;
	endfunction

	function automatic int lowest_full();
		for (int r = 0; r < `BOARD_ROWS; r++) begin
			if (&model_board[r]) begin
				return r;
			end
		end
		return -1;
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// drop, clear and end-of-game rules applied to the model
	task automatic model_round(input int p, input int pos, output int cleared);
		logic [15:0] cells;
		int base;
		int r;
		int c;
		int idx;
		cells = shape_cells(p);
		base = 0;
		for (int k = 0; k < 4; k++) begin
			r = cells[4*k+2 +: 2];
			c = pos + cells[4*k +: 2];
			if (col_height(c) - r > base) begin
				base = col_height(c) - r;
			end
		end
		for (int k = 0; k < 4; k++) begin
			r = base + cells[4*k+2 +: 2];
			c = pos + cells[4*k +: 2];
			if (r < `BOARD_ROWS) begin
				model_board[r][c] = 1'b1;
			end
		end
		cleared = 0;
		idx = lowest_full();
		while (idx >= 0) begin
			for (int j = idx; j < `BOARD_ROWS - 1; j++) begin
				model_board[j] = model_board[j+1];
			end
			model_board[`BOARD_ROWS-1] = '0;
			cleared++;
			idx = lowest_full();
		end
		model_score += cleared;
		model_count++;
		last_fail = 1'b0;
		for (int k = 0; k < `BOARD_COLS; k++) begin
			if (col_height(k) > `VISIBLE_ROWS) begin
				last_fail = 1'b1;
			end
		end
		last_end = last_fail || (model_count == `PIECES_PER_GAME);
	endtask

	// --------------------------------------------------
	// stimulus and checks
	// --------------------------------------------------
	task automatic check_value(input logic ok, input string msg);
		assert (ok) else begin
			mismatches++;
			$display("Mismatch at %0t: %s", $time, msg);
		end
	endtask

	task automatic play_piece(input int p, input int pos);
		int cleared;
		int waited;
		int exp_score;
		logic [`VISIBLE_ROWS*`BOARD_COLS-1:0] exp_tetris;
		model_round(p, pos, cleared);
		// the last round of a game still reports its score before the wipe
		exp_score = model_score;
		exp_tetris = '0;
		if (last_end) begin
			for (int r = 0; r < `VISIBLE_ROWS; r++) begin
				for (int c = 0; c < `BOARD_COLS; c++) begin
					exp_tetris[r*`BOARD_COLS+c] = model_board[r][c];
				end
			end
			model_board = '{default: '0};
			model_score = 0;
			model_count = 0;
		end
		dut_end = 1'b0;
		dut_fail = 1'b0;
		@(posedge clk);
		#1;
		in_valid = 1'b1;
		tetrominoes = piece_t'(p);
		position = col_t'(pos);
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		waited = 0;
		while (!score_valid && waited < 10) begin
			@(posedge clk);
			#1;
			waited++;
		end
		assert (score_valid) else begin
			other_errors++;
			$display("no score_valid within 10 cycles for piece %0d at column %0d", p, pos);
		end
		if (score_valid) begin
			dut_end = tetris_valid;
			dut_fail = fail;
			check_value(waited == cleared + 1,
				$sformatf("score_valid after %0d cycles, expected %0d", waited + 1, cleared + 2));
			check_value(score == score_t'(exp_score),
				$sformatf("score %0d, expected %0d", score, exp_score));
			check_value(fail == last_fail, $sformatf("fail %0b, expected %0b", fail, last_fail));
			check_value(tetris_valid == last_end,
				$sformatf("tetris_valid %0b, expected %0b", tetris_valid, last_end));
			check_value(tetris == exp_tetris, $sformatf("tetris %h, expected %h", tetris, exp_tetris));
		end
	endtask

	task automatic check_idle_outputs();
		repeat (5) begin
			@(posedge clk);
			#1;
			check_value(!tetris_valid && !score_valid && !fail && score == 0 && tetris == 0,
				"outputs not zero before the first piece");
		end
	endtask

	// bytes from the top, high nibble piece and low nibble column
	task automatic play_list(input logic [127:0] seq, input int n);
		for (int k = n - 1; k >= 0; k--) begin
			play_piece(seq[8*k+4 +: 4], seq[8*k +: 4]);
		end
	endtask

	task automatic random_games();
		int games;
		int rounds;
		int p;
		games = 0;
		rounds = 0;
		while (games < 3 && rounds < 60) begin
			rng = xorshift32(rng);
			p = rng % 8;
			rng = xorshift32(rng);
			play_piece(p, rng % (`BOARD_COLS + 1 - shape_width(p)));
			if (dut_end) begin
				games++;
			end
			rounds++;
		end
		assert (games == 3) else begin
			other_errors++;
			$display("random rounds did not complete three games");
		end
	endtask

	initial begin
		rst_n = 1'b0;
		in_valid = 1'b0;
		tetrominoes = '0;
		position = '0;
		rng = 32'd43850;
		model_board = '{default: '0};
		model_score = 0;
		model_count = 0;
		dut_end = 1'b0;
		dut_fail = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check_idle_outputs();
		// all eight shapes, some rows clear on the way, game ends on the 16th piece
		play_list(128'h20_04_10_51_32_64_71_43_00_20_04_12_00_13_04_70, 16);
		assert (dut_end && !dut_fail) else begin
			other_errors++;
			$display("DUT did not end the game on the 16th piece of the shape sequence");
		end
		// two single rows, then four rows under one vertical line
		play_list(72'h20_04_20_10_11_12_13_14_15, 9);
		// one column past the visible rows
		play_list(32'h10_10_10_10, 4);
		assert (dut_fail && dut_end) else begin
			other_errors++;
			$display("DUT did not end the game when the stacked column overflowed");
		end
		play_piece(0, 0);
		random_games();
		$display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
			mismatches, other_errors, DUT.u_assertions.violations);
		if (mismatches == 0 && other_errors == 0 && DUT.u_assertions.violations == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+.
tetris_pkg.sv
board_if.sv
board_store.sv
column_height.sv
piece_lander.sv
game_ctrl.sv
tetris_top.sv
tb_tetris_assertions.sv
tb_tetris.sv
